//--- hw/cpu_pkg.sv
package cpu_pkg;

    ////////////////////
    // datapath widths
    ////////////////////

    localparam int data_w    = 32;
    localparam int reg_sel_w = 5;
    localparam int num_regs  = 32;
    localparam int fl_w      = 2;
    localparam int op_w      = 5;
    localparam int imm_w     = 12;

    // flag bits inside FL
    localparam int fl_z = 0;
    localparam int fl_n = 1;

    ////////////////////
    // instruction fields
    ////////////////////

    // low bit of each field, width comes from the sizes above
    localparam int opc_lo = 27;
    localparam int rd_lo  = 22;
    localparam int rs1_lo = 17;
    localparam int rs2_lo = 12;
    localparam int imm_lo = 0;

    ////////////////////
    // opcodes
    ////////////////////

    // codes 8 and up fall through as no-ops
    typedef enum logic [op_w-1:0] {
        op_add   = 0,
        op_sub   = 1,
        op_and   = 2,
        op_or    = 3,
        op_xor   = 4,
        op_addi  = 5,
        op_cmp   = 6,
        op_moveq = 7
    } alu_op_e;

    ////////////////////
    // decode -> execute
    ////////////////////

    typedef struct packed {
        logic                 valid;
        alu_op_e              op;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] rs1;
        logic [reg_sel_w-1:0] rs2;
        // already sign extended
        logic [data_w-1:0]    imm;
        // false for rd 0, cmp and unknown ops
        logic                 reg_wen;
        logic                 flag_wen;
    } decoded_t;

endpackage

//--- hw/exwb_if.sv
interface exwb_if;

    // register write of the instruction in writeback
    // wen already carries valid and the moveq outcome
    logic                          wen;
    logic [cpu_pkg::reg_sel_w-1:0] rd;
    logic [cpu_pkg::data_w-1:0]    result;

    // flag write, from sub and cmp only
    logic                          flag_wen;
    logic [cpu_pkg::fl_w-1:0]      flag_val;

    // execute stage owns the register
    modport producer (output wen, output rd, output result,
                      output flag_wen, output flag_val);

    // register file write port
    modport sink (input wen, input rd, input result,
                  input flag_wen, input flag_val);

    // forwarding compare only needs the tags
    modport bypass (input rd, input wen, input flag_wen, input flag_val);

endinterface

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [cpu_pkg::data_w-1:0]  instr,
    output cpu_pkg::decoded_t           de_ex
);

    // captured instruction word
    logic                       in_valid;
    logic [cpu_pkg::data_w-1:0] in_instr;

    // decoded fields
    cpu_pkg::alu_op_e           op;
    logic [cpu_pkg::reg_sel_w-1:0] rd;
    logic                       writes_rd;
    cpu_pkg::decoded_t          dec;

    ////////////////////
    // input capture
    ////////////////////

    // a low instr_valid becomes a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        in_instr <= instr;
    end

    ////////////////////
    // field split
    ////////////////////

    assign op = cpu_pkg::alu_op_e'(in_instr[cpu_pkg::opc_lo +: cpu_pkg::op_w]);
    assign rd = in_instr[cpu_pkg::rd_lo +: cpu_pkg::reg_sel_w];

    // ops that produce a register result
    always_comb begin
        case (op)
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
            cpu_pkg::op_or, cpu_pkg::op_xor, cpu_pkg::op_addi,
            cpu_pkg::op_moveq: writes_rd = 1'b1;
            default:           writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        dec.valid    = in_valid;
        dec.op       = op;
        dec.rd       = rd;
        dec.rs1      = in_instr[cpu_pkg::rs1_lo +: cpu_pkg::reg_sel_w];
        dec.rs2      = in_instr[cpu_pkg::rs2_lo +: cpu_pkg::reg_sel_w];
        // sign extend the 12 bit immediate
        dec.imm      = {{(cpu_pkg::data_w - cpu_pkg::imm_w)
                         {in_instr[cpu_pkg::imm_lo + cpu_pkg::imm_w - 1]}},
                        in_instr[cpu_pkg::imm_lo +: cpu_pkg::imm_w]};
        // r0 is hardwired, drop the write here
        dec.reg_wen  = writes_rd && (rd != '0);
        dec.flag_wen = (op == cpu_pkg::op_sub) || (op == cpu_pkg::op_cmp);
    end

    ////////////////////
    // de_ex register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_ex.valid    <= 1'b0;
            de_ex.reg_wen  <= 1'b0;
            de_ex.flag_wen <= 1'b0;
        end else begin
            de_ex <= dec;
        end
    end

endmodule

//--- hw/reg_file.sv
module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    exwb_if.sink                           wb,
    input  logic [cpu_pkg::reg_sel_w-1:0]  rd_sel1,
    input  logic [cpu_pkg::reg_sel_w-1:0]  rd_sel2,
    output logic [cpu_pkg::data_w-1:0]     rd_data1,
    output logic [cpu_pkg::data_w-1:0]     rd_data2,
    output logic [cpu_pkg::fl_w-1:0]       flags
);

    // r1..r31, r0 has no storage
    logic [cpu_pkg::data_w-1:0] regs [1:cpu_pkg::num_regs-1];

    // FL register, bit 0 Z and bit 1 N
    logic [cpu_pkg::fl_w-1:0]   fl_q;

    ////////////////////
    // writeback
    ////////////////////

    // write lands at the edge ending the cycle wb shows it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < cpu_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
            fl_q <= '0;
        end else begin
            // guard r0 even though decode already drops it
            if (wb.wen && (wb.rd != '0)) begin
                regs[wb.rd] <= wb.result;
            end
            if (wb.flag_wen) begin
                fl_q <= wb.flag_val;
            end
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // combinational, no internal bypass
    // the one-behind case is covered by forward_unit
    always_comb begin
        if (rd_sel1 == '0) begin
            rd_data1 = '0;
        end else begin
            rd_data1 = regs[rd_sel1];
        end
    end

    always_comb begin
        if (rd_sel2 == '0) begin
            rd_data2 = '0;
        end else begin
            rd_data2 = regs[rd_sel2];
        end
    end

    // committed flags, also seen at the top level
    assign flags = fl_q;

endmodule

//--- hw/forward_unit.sv
module forward_unit (
    input  cpu_pkg::decoded_t  de_ex,
    exwb_if.bypass             wb,
    output logic               fwd1,
    output logic               fwd2,
    output logic               fwd_fl
);

    // pending write that is visible to forwarding
    logic wb_hit_ok;

    // only moveq looks at the flags
    logic reads_fl;

    ////////////////////
    // register sources
    ////////////////////

    // r0 never forwards, it must read as zero
    assign wb_hit_ok = wb.wen && (wb.rd != '0);

    // rs1 one place behind its writer
    assign fwd1 = wb_hit_ok && (wb.rd == de_ex.rs1);

    // rs2 same check
    assign fwd2 = wb_hit_ok && (wb.rd == de_ex.rs2);

    ////////////////////
    // flags
    ////////////////////

    assign reads_fl = de_ex.valid && (de_ex.op == cpu_pkg::op_moveq);

    // cmp or sub right in front, FL not yet updated
    // so moveq takes the fresh Z from writeback
    assign fwd_fl = reads_fl && wb.flag_wen;

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cpu_pkg::decoded_t              de_ex,
    input  logic [cpu_pkg::data_w-1:0]     rd_data1,
    input  logic [cpu_pkg::data_w-1:0]     rd_data2,
    input  logic [cpu_pkg::fl_w-1:0]       flags,
    input  logic                           fwd1,
    input  logic                           fwd2,
    input  logic                           fwd_fl,
    output logic [cpu_pkg::reg_sel_w-1:0]  rd_sel1,
    output logic [cpu_pkg::reg_sel_w-1:0]  rd_sel2,
    exwb_if.producer                       wb
);

    // operands after forwarding
    logic [cpu_pkg::data_w-1:0] opa;
    logic [cpu_pkg::data_w-1:0] opb;
    logic [cpu_pkg::fl_w-1:0]   fl_in;

    // alu outputs
    logic [cpu_pkg::data_w-1:0] alu_out;
    logic [cpu_pkg::fl_w-1:0]   fl_out;

    // final write decision
    logic                       do_wen;
    logic                       do_flag_wen;

    ////////////////////
    // operand select
    ////////////////////

    assign rd_sel1 = de_ex.rs1;
    assign rd_sel2 = de_ex.rs2;

    // pending result wins over the register file
    assign opa   = fwd1 ? wb.result : rd_data1;
    assign opb   = fwd2 ? wb.result : rd_data2;
    assign fl_in = fwd_fl ? wb.flag_val : flags;

    ////////////////////
    // alu
    ////////////////////

    always_comb begin
        case (de_ex.op)
            cpu_pkg::op_add:   alu_out = opa + opb;
            // cmp shares the subtractor
            cpu_pkg::op_sub,
            cpu_pkg::op_cmp:   alu_out = opa - opb;
            cpu_pkg::op_and:   alu_out = opa & opb;
            cpu_pkg::op_or:    alu_out = opa | opb;
            cpu_pkg::op_xor:   alu_out = opa ^ opb;
            cpu_pkg::op_addi:  alu_out = opa + de_ex.imm;
            // plain move of rs1, gated below
            cpu_pkg::op_moveq: alu_out = opa;
            default:           alu_out = '0;
        endcase
    end

    // Z and N from the result
    assign fl_out[cpu_pkg::fl_z] = (alu_out == '0);
    assign fl_out[cpu_pkg::fl_n] = alu_out[cpu_pkg::data_w-1];

    // moveq only writes when Z is set
    always_comb begin
        do_wen = de_ex.valid && de_ex.reg_wen;
        if (de_ex.op == cpu_pkg::op_moveq) begin
            do_wen = do_wen && fl_in[cpu_pkg::fl_z];
        end
    end

    assign do_flag_wen = de_ex.valid && de_ex.flag_wen;

    ////////////////////
    // ex_wb register
    ////////////////////

    // bubbles clear both enables
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.wen      <= 1'b0;
            wb.flag_wen <= 1'b0;
        end else begin
            wb.wen      <= do_wen;
            wb.flag_wen <= do_flag_wen;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        wb.rd       <= de_ex.rd;
        wb.result   <= alu_out;
        wb.flag_val <= fl_out;
    end

endmodule

//--- hw/cpu.sv
module cpu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::data_w-1:0]     instr,
    output logic                           wb_valid,
    output logic [cpu_pkg::reg_sel_w-1:0]  wb_sel,
    output logic [cpu_pkg::data_w-1:0]     wb_data,
    output logic [cpu_pkg::fl_w-1:0]       flags
);

    // decode to execute
    cpu_pkg::decoded_t             de_ex;

    // register file read ports
    logic [cpu_pkg::reg_sel_w-1:0] rd_sel1;
    logic [cpu_pkg::reg_sel_w-1:0] rd_sel2;
    logic [cpu_pkg::data_w-1:0]    rd_data1;
    logic [cpu_pkg::data_w-1:0]    rd_data2;

    // forwarding selects
    logic                          fwd1;
    logic                          fwd2;
    logic                          fwd_fl;

    // execute to writeback
    exwb_if exwb ();

    ////////////////////
    // stages
    ////////////////////

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .de_ex       (de_ex)
    );

    // reads and forwarding run side by side
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb       (exwb.sink),
        .rd_sel1  (rd_sel1),
        .rd_sel2  (rd_sel2),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .flags    (flags)
    );

    forward_unit u_forward (
        .de_ex  (de_ex),
        .wb     (exwb.bypass),
        .fwd1   (fwd1),
        .fwd2   (fwd2),
        .fwd_fl (fwd_fl)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_ex    (de_ex),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .flags    (flags),
        .fwd1     (fwd1),
        .fwd2     (fwd2),
        .fwd_fl   (fwd_fl),
        .rd_sel1  (rd_sel1),
        .rd_sel2  (rd_sel2),
        .wb       (exwb.producer)
    );

    // writeback shown at the ports
    assign wb_valid = exwb.wen;
    assign wb_sel   = exwb.rd;
    assign wb_data  = exwb.result;

endmodule

//--- verification/cpu_tests.svh
    ////////////////////
    // directed tests
    ////////////////////

    // quiet core, no writes and clear flags
    task automatic test_idle_after_reset();
        cur_test = "idle_after_reset";
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check("wb_valid", 32'd0, 32'(wb_valid));
            check("flags", 32'd0, 32'(flags));
        end
    endtask

    task automatic test_dependent_alu();
        cur_test = "dependent_alu";
        send(encode_instr(cpu_pkg::op_addi, 5'd1, 5'd0, 5'd0, 12'd100));
        // -7
        send(encode_instr(cpu_pkg::op_addi, 5'd2, 5'd0, 5'd0, 12'hff9));
        // r2 one place behind, r1 two behind
        send(encode_instr(cpu_pkg::op_add, 5'd3, 5'd1, 5'd2, 12'd0));
        send(encode_instr(cpu_pkg::op_sub, 5'd4, 5'd3, 5'd1, 12'd0));
        send(encode_instr(cpu_pkg::op_and, 5'd5, 5'd4, 5'd3, 12'd0));
        send(encode_instr(cpu_pkg::op_or, 5'd6, 5'd5, 5'd4, 12'd0));
        send(encode_instr(cpu_pkg::op_xor, 5'd7, 5'd6, 5'd5, 12'd0));
        bubble(1);
        // r7 two behind across a bubble
        send(encode_instr(cpu_pkg::op_add, 5'd8, 5'd7, 5'd7, 12'd0));
        // both ports forwarded, result zero
        send(encode_instr(cpu_pkg::op_sub, 5'd9, 5'd8, 5'd8, 12'd0));
        drain_and_check_flags();
        check("flags after zero sub", 32'd1, 32'(flags));
    endtask

    task automatic test_addi_sign_ext();
        cur_test = "addi_sign_ext";
        // most negative immediate
        send(encode_instr(cpu_pkg::op_addi, 5'd10, 5'd0, 5'd0, 12'h800));
        send(encode_instr(cpu_pkg::op_addi, 5'd11, 5'd10, 5'd0, 12'h7ff));
        send(encode_instr(cpu_pkg::op_addi, 5'd12, 5'd11, 5'd0, 12'hfff));
        send(encode_instr(cpu_pkg::op_addi, 5'd13, 5'd0, 5'd0, 12'h001));
        bubble(2);
        send(encode_instr(cpu_pkg::op_addi, 5'd14, 5'd12, 5'd0, 12'd5));
        drain_and_check_flags();
    endtask

    task automatic test_cmp_moveq();
        cur_test = "cmp_moveq";
        send(encode_instr(cpu_pkg::op_addi, 5'd20, 5'd0, 5'd0, 12'd5));
        send(encode_instr(cpu_pkg::op_addi, 5'd21, 5'd0, 5'd0, 12'd5));
        send(encode_instr(cpu_pkg::op_addi, 5'd22, 5'd0, 5'd0, 12'd9));
        // equal, adjacent moveq takes flags from writeback
        send(encode_instr(cpu_pkg::op_cmp, 5'd0, 5'd20, 5'd21, 12'd0));
        send(encode_instr(cpu_pkg::op_moveq, 5'd23, 5'd22, 5'd0, 12'd0));
        // 5 - 9, no move
        send(encode_instr(cpu_pkg::op_cmp, 5'd0, 5'd20, 5'd22, 12'd0));
        send(encode_instr(cpu_pkg::op_moveq, 5'd24, 5'd22, 5'd0, 12'd0));
        drain_and_check_flags();
        check("flags after negative cmp", 32'd2, 32'(flags));
        // committed flags once bubbles separate them
        send(encode_instr(cpu_pkg::op_cmp, 5'd0, 5'd21, 5'd20, 12'd0));
        bubble(2);
        send(encode_instr(cpu_pkg::op_moveq, 5'd25, 5'd22, 5'd0, 12'd0));
        send(encode_instr(cpu_pkg::op_cmp, 5'd0, 5'd22, 5'd20, 12'd0));
        bubble(1);
        send(encode_instr(cpu_pkg::op_moveq, 5'd26, 5'd20, 5'd0, 12'd0));
        // sub also sets Z for the next moveq
        send(encode_instr(cpu_pkg::op_sub, 5'd27, 5'd20, 5'd21, 12'd0));
        send(encode_instr(cpu_pkg::op_moveq, 5'd28, 5'd22, 5'd0, 12'd0));
        drain_and_check_flags();
        check("flags after zero sub", 32'd1, 32'(flags));
    endtask

    task automatic test_r0_and_unknown();
        cur_test = "r0_and_unknown";
        send(encode_instr(cpu_pkg::op_add, 5'd0, 5'd20, 5'd22, 12'd0));
        send(encode_instr(cpu_pkg::op_addi, 5'd0, 5'd0, 5'd0, 12'd55));
        // opcodes past moveq do nothing
        send(encode_instr(5'd9, 5'd5, 5'd20, 5'd22, 12'd0));
        send(encode_instr(5'd31, 5'd6, 5'd22, 5'd20, 12'hfff));
        // flags change, r0 stays zero
        send(encode_instr(cpu_pkg::op_sub, 5'd0, 5'd22, 5'd20, 12'd0));
        send(encode_instr(cpu_pkg::op_add, 5'd29, 5'd0, 5'd0, 12'd0));
        send(encode_instr(cpu_pkg::op_addi, 5'd30, 5'd0, 5'd0, 12'd3));
        drain_and_check_flags();
    endtask

    // small register window for more hazards
    task automatic test_random_stream();
        logic [4:0] op;
        cur_test = "random_stream";
        for (int i = 0; i < 200; i++) begin
            op = 5'($urandom_range(7, 0));
            send(encode_instr(op, 5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                              5'($urandom_range(7, 0)), 12'($urandom())));
            if ($urandom_range(3, 0) == 0) begin
                bubble(int'($urandom_range(2, 1)));
            end
        end
        drain_and_check_flags();
    endtask

//--- verification/cpu_tb.sv
module cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // one slot per accepted instruction
    // due is the edge count after which the write shows
    typedef struct packed {
        logic        wen;
        logic [4:0]  sel;
        logic [31:0] data;
        logic [31:0] due;
    } wb_exp_t;

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          instr_valid;
    logic [cpu_pkg::data_w-1:0]    instr;
    logic                          wb_valid;
    logic [cpu_pkg::reg_sel_w-1:0] wb_sel;
    logic [cpu_pkg::data_w-1:0]    wb_data;
    logic [cpu_pkg::fl_w-1:0]      flags;

    // rising edges seen so far
    logic [31:0] cyc = '0;
    logic        mon_en;
    string       cur_test;

    // reference model in program order
    logic [31:0] model_regs [32];
    logic [1:0]  model_fl;
    wb_exp_t     exp_q [$];

    cpu u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data),
        .flags       (flags)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    ////////////////////
    // reporting
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: test %s, %s expected %h actual %h", cur_test, what, exp, act);
            abort_run("value mismatch");
        end
    endtask

    ////////////////////
    // stimulus and model
    ////////////////////

    // opcode, rd, rs1, rs2, imm from msb down
    function automatic logic [31:0] encode_instr(input logic [4:0] op, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [11:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic model_step(input logic [31:0] word);
        logic [4:0]  op;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        writes;
        logic        sets_fl;
        wb_exp_t     e;
        op      = word[31:27];
        rd      = word[26:22];
        a       = model_regs[word[21:17]];
        b       = model_regs[word[16:12]];
        res     = '0;
        writes  = 1'b0;
        sets_fl = 1'b0;
        case (op)
            cpu_pkg::op_add: begin
                res    = a + b;
                writes = 1'b1;
            end
            cpu_pkg::op_sub: begin
                res     = a - b;
                writes  = 1'b1;
                sets_fl = 1'b1;
            end
            cpu_pkg::op_and: begin
                res    = a & b;
                writes = 1'b1;
            end
            cpu_pkg::op_or: begin
                res    = a | b;
                writes = 1'b1;
            end
            cpu_pkg::op_xor: begin
                res    = a ^ b;
                writes = 1'b1;
            end
            cpu_pkg::op_addi: begin
                res    = a + {{20{word[11]}}, word[11:0]};
                writes = 1'b1;
            end
            cpu_pkg::op_cmp: begin
                res     = a - b;
                sets_fl = 1'b1;
            end
            // move only on Z
            cpu_pkg::op_moveq: begin
                res    = a;
                writes = model_fl[0];
            end
            default: ;
        endcase
        // N then Z
        if (sets_fl) begin
            model_fl = {res[31], (res == 32'd0)};
        end
        writes = writes && (rd != 5'd0);
        if (writes) begin
            model_regs[rd] = res;
        end
        // accepted at the next edge and shown two edges later
        e.wen  = writes;
        e.sel  = rd;
        e.data = res;
        e.due  = cyc + 32'd3;
        exp_q.push_back(e);
    endtask

    task automatic send(input logic [31:0] word);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        model_step(word);
    endtask

    // garbage on instr with valid low
    task automatic bubble(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            instr_valid = 1'b0;
            instr       = $urandom();
        end
    endtask

    task automatic drain_and_check_flags();
        int waited;
        waited = 0;
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            if (waited == 20) begin
                abort_run("timeout, the core gave no write within 20 cycles");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        // FL commits one edge after writeback
        @(negedge clk);
        check("flags", 32'(model_fl), 32'(flags));
    endtask

    ////////////////////
    // writeback monitor
    ////////////////////

    // outputs settle after the rising edge so sample on the falling one
    always @(negedge clk) begin
        wb_exp_t e;
        if (mon_en) begin
            if ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
                e = exp_q.pop_front();
                check("wb_valid", 32'(e.wen), 32'(wb_valid));
                if (e.wen) begin
                    check("wb_sel", 32'(e.sel), 32'(wb_sel));
                    check("wb_data", e.data, wb_data);
                end
            end else if (wb_valid) begin
                abort_run("wb_valid went high with no write due");
            end
        end
    end

    `include "cpu_tests.svh"

    initial begin
        void'($urandom(32'h45dc_b95e));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        mon_en      = 1'b0;
        model_fl    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n  = 1'b1;
        mon_en = 1'b1;
        test_idle_after_reset();
        test_dependent_alu();
        test_addi_sign_ext();
        test_cmp_moveq();
        test_r0_and_unknown();
        test_random_stream();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
hw/cpu_pkg.sv
hw/exwb_if.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/cpu.sv
verification/cpu_tb.sv
+incdir+verification

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
SIM_DIR   ?= obj_dir

SRCS    := $(shell grep -v '^+' compile.f)
HDRS    := $(wildcard verification/*.svh)
SIM_BIN := $(SIM_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) compile.f
	$(VERILATOR) --binary --timing --top-module $(TOP) -f compile.f \
		--Mdir $(SIM_DIR) -o V$(TOP)

# the simulator exit status is the verdict
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(SIM_DIR)
